// ==== files.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_stage_reg.sv
src/reg_file.sv
src/hazard_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/int_core_top.sv
verification/core_tb.sv

// ==== Makefile ====
# Verilator build and run for the integer core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/core_tb.sv ====
`timescale 1ns/1ns

module core_tb import isa_pkg::*; ();

    localparam int NUM_INST    = 400;
    localparam int CYCLE_LIMIT = 20 * NUM_INST;

    logic      aclk;
    logic      reset;
    logic      inst_valid;
    word_t     inst_word;
    word_t     inst_pc;
    logic      inst_ready;
    logic      trace_ready;
    logic      debug_wb_valid;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    int          seed;
    int          errors;
    int          checks;
    int          cycles;
    int          sent;
    int          retired;
    logic        timed_out;
    logic        done;
    word_t       model_regs [32];
    logic [63:0] pending [$];
    word_t       last_cnt_lo;
    logic        cnt_lo_seen;
    logic        hold_armed;
    logic [69:0] trace_snapshot;
    word_t       rnd;
    word_t       next_word;
    logic [5:0]  known_ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLTU,
                                   OP_MUL, OP_RDCNT_LO, OP_RDCNT_HI};

    int_core_top int_core_top_inst (
        .aclk(aclk), .reset(reset),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc),
        .inst_ready(inst_ready), .trace_ready(trace_ready),
        .debug_wb_valid(debug_wb_valid), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #10 aclk = ~aclk;
        end
    end

    function automatic word_t make_inst(input logic [5:0] opcode, input reg_addr_t rd,
                                        input reg_addr_t rj, input reg_addr_t rk);
        word_t w;
        w = '0;
        w[OPCODE_LSB +: 6] = opcode;
        w[RD_LSB +: 5]     = rd;
        w[RJ_LSB +: 5]     = rj;
        w[RK_LSB +: 5]     = rk;
        return w;
    endfunction

    function automatic logic is_known_op(input logic [5:0] opcode);
        logic known;
        known = 1'b0;
        foreach (known_ops[i])
        begin
            if (known_ops[i] == opcode)
            begin
                known = 1'b1;
            end
        end
        return known;
    endfunction

    // Architectural result of one instruction
    function automatic word_t expect_result(input logic [5:0] opcode, input word_t a,
                                            input word_t b);
        case (opcode)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic next_inst(output word_t w);
        word_t      r;
        logic [5:0] opcode;
        r = $random(seed);
        if (sent < 3)
        begin
            // Give r1..r3 known values before anything reads them
            w = make_inst(OP_RDCNT_LO, reg_addr_t'(sent + 1), '0, '0);
        end
        else
        begin
            case (r[3:0])
                4'd9, 4'd10, 4'd11: opcode = OP_MUL;
                4'd12, 4'd13:       opcode = OP_ADD;
                4'd14, 4'd15:       opcode = {1'b1, r[30:26]};
                default:            opcode = known_ops[r[3:0]];
            endcase
            // Pool r0..r3 keeps dependencies dense
            w = make_inst(opcode, {3'b000, r[5:4]}, {3'b000, r[7:6]}, {3'b000, r[9:8]});
        end
    endtask

    task automatic check_retire();
        logic [63:0] head;
        logic [5:0]  opcode;
        reg_addr_t   rd;
        logic        exp_we;
        word_t       exp_data;
        checks++;
        assert (pending.size() > 0)
        else
        begin
            errors++;
            $display("Retirement at %0t with no accepted instruction outstanding", $time);
        end
        if (pending.size() > 0)
        begin
            head     = pending.pop_front();
            opcode   = head[OPCODE_LSB +: 6];
            rd       = head[RD_LSB +: 5];
            exp_we   = is_known_op(opcode) && (rd != '0);
            exp_data = expect_result(opcode, model_regs[head[RJ_LSB +: 5]],
                                     model_regs[head[RK_LSB +: 5]]);
            retired++;
            check_value("debug_wb_pc", debug_wb_pc, head[63:32]);
            check_value("debug_wb_rf_we", {31'b0, debug_wb_rf_we}, {31'b0, exp_we});
            check_value("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, {27'b0, rd});
            if (opcode == OP_RDCNT_LO)
            begin
                checks++;
                assert (!cnt_lo_seen || (debug_wb_rf_wdata > last_cnt_lo))
                else
                begin
                    errors++;
                    $display("Error at %0t: debug_wb_rf_wdata rdcnt low %h not above %h",
                             $time, debug_wb_rf_wdata, last_cnt_lo);
                end
                cnt_lo_seen = 1'b1;
                last_cnt_lo = debug_wb_rf_wdata;
                exp_data    = debug_wb_rf_wdata;
            end
            else if (opcode == OP_RDCNT_HI)
            begin
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, '0);
            end
            else if (exp_we)
            begin
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data);
            end
            if (exp_we)
            begin
                model_regs[rd] = exp_data;
            end
        end
    endtask

    initial
    begin
        seed        = 32'h65dd_8aee;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        sent        = 0;
        retired     = 0;
        timed_out   = 1'b0;
        done        = 1'b0;
        cnt_lo_seen = 1'b0;
        last_cnt_lo = '0;
        hold_armed  = 1'b0;
        trace_snapshot = '0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst_word   = '0;
        inst_pc     = '0;
        trace_ready = 1'b0;

        repeat (10) @(posedge aclk);
        reset <= 1'b0;
        @(posedge aclk);
        check_value("debug_wb_valid", {31'b0, debug_wb_valid}, 32'd0);
        check_value("inst_ready", {31'b0, inst_ready}, 32'd1);

        while (!done && !timed_out)
        begin
            if (debug_wb_valid && trace_ready)
            begin
                check_retire();
            end
            // Stalled trace must not move
            if (hold_armed)
            begin
                checks++;
                assert (debug_wb_valid && (trace_snapshot == {debug_wb_pc, debug_wb_rf_we,
                        debug_wb_rf_wnum, debug_wb_rf_wdata}))
                else
                begin
                    errors++;
                    $display("Trace outputs changed at %0t while trace_ready was low", $time);
                end
            end
            hold_armed     = debug_wb_valid && !trace_ready;
            trace_snapshot = {debug_wb_pc, debug_wb_rf_we, debug_wb_rf_wnum, debug_wb_rf_wdata};
            if (inst_valid && inst_ready)
            begin
                pending.push_back({inst_pc, inst_word});
                sent++;
            end

            rnd = $random(seed);
            trace_ready <= rnd[0] | rnd[1];
            // An offer already on the port stays until taken
            if (!inst_valid || inst_ready)
            begin
                if ((sent < NUM_INST) && (rnd[2] | rnd[3]))
                begin
                    next_inst(next_word);
                    inst_valid <= 1'b1;
                    inst_word  <= next_word;
                    inst_pc    <= 32'h1c00_0000 + 4 * sent;
                end
                else
                begin
                    inst_valid <= 1'b0;
                end
            end

            cycles++;
            done = (sent == NUM_INST) && (pending.size() == 0);
            if (!done && (cycles > CYCLE_LIMIT))
            begin
                timed_out = 1'b1;
                $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                         cycles, retired, NUM_INST);
            end
            @(posedge aclk);
        end

        // Four stages deep, so a stray extra retirement shows up within a few cycles
        if (!timed_out)
        begin
            repeat (6)
            begin
                if (debug_wb_valid && trace_ready)
                begin
                    check_retire();
                end
                trace_ready <= 1'b1;
                @(posedge aclk);
            end
        end

        $display("Checks run: %0d, errors: %0d, retired: %0d", checks, errors, retired);
        if ((errors == 0) && !timed_out)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src/int_core_top.sv ====
`timescale 1ns/1ns

module int_core_top import isa_pkg::*, pipe_pkg::*; (
    input  logic      aclk,
    input  logic      reset,
    input  logic      inst_valid,
    input  word_t     inst_word,
    input  word_t     inst_pc,
    output logic      inst_ready,
    input  logic      trace_ready,
    output logic      debug_wb_valid,
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    id_entry_t  id_in;
    id_entry_t  id_q;
    logic       id_valid;
    logic       issue_valid;
    logic       issue_leave;
    ex_entry_t  issue_entry;
    logic       ex_valid;
    logic       ex_allow_in;
    ex_entry_t  ex_q;
    mem_entry_t mem_next;
    logic       mem_valid;
    logic       mem_allow_in;
    mem_entry_t mem_q;
    word_t      mem_result;
    wb_entry_t  wb_next;
    logic       wb_allow_in;
    wb_entry_t  wb_q;
    reg_addr_t  src1_addr;
    reg_addr_t  src2_addr;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      operand1;
    word_t      operand2;
    logic       pause;

    assign id_in.pc   = inst_pc;
    assign id_in.inst = inst_word;

    pipe_stage_reg #(.payload_t(id_entry_t)) u_id_reg (
        .aclk(aclk), .reset(reset),
        .in_valid(inst_valid), .in_data(id_in), .leave(issue_leave),
        .out_valid(id_valid), .out_data(id_q), .allow_in(inst_ready)
    );

    decode_stage u_decode (
        .id_valid(id_valid), .id_entry(id_q),
        .operand1(operand1), .operand2(operand2),
        .pause(pause), .ex_allow_in(ex_allow_in),
        .src1_addr(src1_addr), .src2_addr(src2_addr),
        .issue_valid(issue_valid), .issue_entry(issue_entry), .issue_leave(issue_leave)
    );

    reg_file u_reg_file (
        .aclk(aclk),
        .raddr1(src1_addr), .raddr2(src2_addr),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .wb_valid(debug_wb_valid), .wb_write(wb_q.write),
        .wb_dest(wb_q.dest), .wb_data(wb_q.result),
        .trace_ready(trace_ready)
    );

    hazard_unit u_hazard (
        .src1_addr(src1_addr), .src2_addr(src2_addr),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_valid(ex_valid), .ex_entry(ex_q), .ex_result(mem_next.result),
        .mem_valid(mem_valid), .mem_dest(mem_q.dest),
        .mem_write(mem_q.write), .mem_result(mem_result),
        .wb_valid(debug_wb_valid), .wb_entry(wb_q),
        .operand1(operand1), .operand2(operand2), .pause(pause)
    );

    pipe_stage_reg #(.payload_t(ex_entry_t)) u_ex_reg (
        .aclk(aclk), .reset(reset),
        .in_valid(issue_valid), .in_data(issue_entry), .leave(mem_allow_in),
        .out_valid(ex_valid), .out_data(ex_q), .allow_in(ex_allow_in)
    );

    execute_stage u_execute (
        .aclk(aclk), .reset(reset),
        .ex_valid(ex_valid), .ex_entry(ex_q),
        .mem_allow_in(mem_allow_in), .mem_entry(mem_next)
    );

    pipe_stage_reg #(.payload_t(mem_entry_t)) u_mem_reg (
        .aclk(aclk), .reset(reset),
        .in_valid(ex_valid), .in_data(mem_next), .leave(wb_allow_in),
        .out_valid(mem_valid), .out_data(mem_q), .allow_in(mem_allow_in)
    );

    memory_stage u_memory (
        .mem_entry(mem_q), .mem_result(mem_result), .wb_entry(wb_next)
    );

    // Trace consumer back-pressure enters here
    pipe_stage_reg #(.payload_t(wb_entry_t)) u_wb_reg (
        .aclk(aclk), .reset(reset),
        .in_valid(mem_valid), .in_data(wb_next), .leave(trace_ready),
        .out_valid(debug_wb_valid), .out_data(wb_q), .allow_in(wb_allow_in)
    );

    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_we    = wb_q.write;
    assign debug_wb_rf_wnum  = wb_q.dest;
    assign debug_wb_rf_wdata = wb_q.result;

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage import isa_pkg::*, pipe_pkg::*; (
    input  mem_entry_t mem_entry,
    output word_t      mem_result,
    output wb_entry_t  wb_entry
);

    word_t cross_sum;
    word_t mul_result;

    // Cross terms land 16 bits up and overflow past bit 31 is dropped
    assign cross_sum  = mem_entry.pp_lh + mem_entry.pp_hl;
    assign mul_result = mem_entry.pp_ll + (cross_sum << 16);

    assign mem_result = mem_entry.mul ? mul_result : mem_entry.result;

    always_comb
    begin
        wb_entry.pc     = mem_entry.pc;
        wb_entry.dest   = mem_entry.dest;
        wb_entry.write  = mem_entry.write;
        wb_entry.result = mem_result;
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic       aclk,
    input  logic       reset,
    input  logic       ex_valid,
    input  ex_entry_t  ex_entry,
    input  logic       mem_allow_in,
    output mem_entry_t mem_entry
);

    logic [63:0] cycle_cnt;
    word_t       a;
    word_t       b;
    word_t       alu_result;
    logic        is_mul;
    logic        mul_go;
    word_t       mul_a;
    word_t       mul_b;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            cycle_cnt <= '0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    assign a = ex_entry.operand1;
    assign b = ex_entry.operand2;

    always_comb
    begin
        case (ex_entry.alu_op)
            ALU_ADD:    alu_result = a + b;
            ALU_SUB:    alu_result = a - b;
            ALU_AND:    alu_result = a & b;
            ALU_OR:     alu_result = a | b;
            ALU_XOR:    alu_result = a ^ b;
            ALU_SLTU:   alu_result = {31'b0, a < b};
            ALU_CNT_LO: alu_result = cycle_cnt[31:0];
            ALU_CNT_HI: alu_result = cycle_cnt[63:32];
            default:    alu_result = '0;
        endcase
    end

    // Multiplier inputs held quiet unless a multiply moves into MEM
    assign is_mul = ex_entry.alu_op == ALU_MUL;
    assign mul_go = ex_valid & is_mul & mem_allow_in;
    assign mul_a  = mul_go ? a : '0;
    assign mul_b  = mul_go ? b : '0;

    always_comb
    begin
        mem_entry.pc     = ex_entry.pc;
        mem_entry.dest   = ex_entry.dest;
        mem_entry.write  = ex_entry.write;
        mem_entry.mul    = is_mul;
        mem_entry.result = alu_result;
        // ah*bh drops out of the low 32 bits
        mem_entry.pp_ll  = {16'b0, mul_a[15:0]} * {16'b0, mul_b[15:0]};
        mem_entry.pp_lh  = {16'b0, mul_a[15:0]} * {16'b0, mul_b[31:16]};
        mem_entry.pp_hl  = {16'b0, mul_a[31:16]} * {16'b0, mul_b[15:0]};
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      id_valid,
    input  id_entry_t id_entry,
    input  word_t     operand1,
    input  word_t     operand2,
    input  logic      pause,
    input  logic      ex_allow_in,
    output reg_addr_t src1_addr,
    output reg_addr_t src2_addr,
    output logic      issue_valid,
    output ex_entry_t issue_entry,
    output logic      issue_leave
);

    opcode_e   opcode;
    reg_addr_t rd;
    alu_op_e   alu_op;

    assign opcode    = opcode_e'(id_entry.inst[OPCODE_LSB +: $bits(opcode_e)]);
    assign rd        = id_entry.inst[RD_LSB +: $bits(reg_addr_t)];
    assign src1_addr = id_entry.inst[RJ_LSB +: $bits(reg_addr_t)];
    assign src2_addr = id_entry.inst[RK_LSB +: $bits(reg_addr_t)];

    always_comb
    begin
        case (opcode)
            OP_ADD:      alu_op = ALU_ADD;
            OP_SUB:      alu_op = ALU_SUB;
            OP_AND:      alu_op = ALU_AND;
            OP_OR:       alu_op = ALU_OR;
            OP_XOR:      alu_op = ALU_XOR;
            OP_SLTU:     alu_op = ALU_SLTU;
            OP_MUL:      alu_op = ALU_MUL;
            OP_RDCNT_LO: alu_op = ALU_CNT_LO;
            OP_RDCNT_HI: alu_op = ALU_CNT_HI;
            default:     alu_op = ALU_NOP;
        endcase
    end

    always_comb
    begin
        issue_entry.pc       = id_entry.pc;
        issue_entry.alu_op   = alu_op;
        issue_entry.dest     = rd;
        // Unknown opcodes and r0 retire without a write
        issue_entry.write    = (alu_op != ALU_NOP) && (rd != '0);
        issue_entry.operand1 = operand1;
        issue_entry.operand2 = operand2;
    end

    // A paused entry stays put and EX takes a bubble
    assign issue_valid = id_valid & ~pause;
    assign issue_leave = ex_allow_in & ~pause;

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t src1_addr,
    input  reg_addr_t src2_addr,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  logic      ex_valid,
    input  ex_entry_t ex_entry,
    input  word_t     ex_result,
    input  logic      mem_valid,
    input  reg_addr_t mem_dest,
    input  logic      mem_write,
    input  word_t     mem_result,
    input  logic      wb_valid,
    input  wb_entry_t wb_entry,
    output word_t     operand1,
    output word_t     operand2,
    output logic      pause
);

    function automatic logic ex_hit(input reg_addr_t src);
        return ex_valid && ex_entry.write && (ex_entry.dest == src) && (src != '0);
    endfunction

    // Youngest writer first, then the register file
    function automatic word_t pick(input reg_addr_t src, input word_t rf_value);
        word_t value;
        value = rf_value;
        if (ex_hit(src) && (ex_entry.alu_op != ALU_MUL))
        begin
            value = ex_result;
        end
        else if (mem_valid && mem_write && (mem_dest == src) && (src != '0))
        begin
            value = mem_result;
        end
        else if (wb_valid && wb_entry.write && (wb_entry.dest == src) && (src != '0))
        begin
            value = wb_entry.result;
        end
        return value;
    endfunction

    always_comb
    begin
        operand1 = pick(src1_addr, rf_rdata1);
        operand2 = pick(src2_addr, rf_rdata2);
        // Multiply result exists only once it reaches MEM
        pause = (ex_hit(src1_addr) || ex_hit(src2_addr)) && (ex_entry.alu_op == ALU_MUL);
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import isa_pkg::*; (
    input  logic      aclk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      wb_valid,
    input  logic      wb_write,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    input  logic      trace_ready
);

    word_t regs [32];

    // Commit only when the WB entry actually retires
    always_ff @(posedge aclk)
    begin
        if (wb_valid && trace_ready && wb_write)
        begin
            regs[wb_dest] <= wb_data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/pipe_stage_reg.sv ====
`timescale 1ns/1ns

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     leave,
    output logic     out_valid,
    output payload_t out_data,
    output logic     allow_in
);

    // Empty, or the held entry moves on this cycle
    assign allow_in = ~out_valid | leave;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (allow_in)
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (allow_in)
        begin
            out_data <= in_data;
        end
    end

endmodule

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_NOP    = 4'd0,
        ALU_ADD    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_AND    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_MUL    = 4'd7,
        ALU_CNT_LO = 4'd8,
        ALU_CNT_HI = 4'd9
    } alu_op_e;

    // Between the instruction port and decode
    typedef struct packed {
        word_t pc;
        word_t inst;
    } id_entry_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        reg_addr_t dest;
        logic      write;
        word_t     operand1;
        word_t     operand2;
    } ex_entry_t;

    // Multiply travels as three partial products, summed in MEM
    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      write;
        logic      mul;
        word_t     result;
        word_t     pp_ll;
        word_t     pp_lh;
        word_t     pp_hl;
    } mem_entry_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      write;
        word_t     result;
    } wb_entry_t;

endpackage

// ==== src/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcode in bits 31..26 of the instruction word
    typedef enum logic [5:0] {
        OP_ADD      = 6'h01,
        OP_SUB      = 6'h02,
        OP_AND      = 6'h03,
        OP_OR       = 6'h04,
        OP_XOR      = 6'h05,
        OP_SLTU     = 6'h06,
        OP_MUL      = 6'h07,
        OP_RDCNT_LO = 6'h08,
        OP_RDCNT_HI = 6'h09
    } opcode_e;

    // Field positions in the instruction word
    localparam int RD_LSB     = 0;
    localparam int RJ_LSB     = 5;
    localparam int RK_LSB     = 10;
    localparam int OPCODE_LSB = 26;

endpackage
